// File: Bender.yml
package:
  name: vec_core

sources:
  - logic/VecPkg.sv
  - logic/FetchUnit.sv
  - logic/VecRegFile.sv
  - logic/DecodeStage.sv
  - logic/HazardUnit.sv
  - logic/ExecuteStage.sv
  - logic/WritebackStage.sv
  - logic/VecCore.sv
  - target: test
    files:
      - test/VecCoreChecker.sv
      - test/VecCoreTb.sv

// File: compile.f
logic/VecPkg.sv
logic/FetchUnit.sv
logic/VecRegFile.sv
logic/DecodeStage.sv
logic/HazardUnit.sv
logic/ExecuteStage.sv
logic/WritebackStage.sv
logic/VecCore.sv
test/VecCoreChecker.sv
test/VecCoreTb.sv

// File: logic/DecodeStage.sv
module DecodeStage (
    input  logic                                                CLK,
    input  logic                                                rstN,
    input  logic                                                bubble,
    input  logic [VecPkg::instrWidth-1:0]                       instrD,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] rd1,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] rd2,
    output logic [VecPkg::regAddrWidth-1:0]                     ra1,
    output logic [VecPkg::regAddrWidth-1:0]                     ra2,
    output logic [3:0]                                          aluOpE,
    output logic [1:0]                                          classE,
    output logic [VecPkg::regAddrWidth-1:0]                     wa3E,
    output logic [VecPkg::regAddrWidth-1:0]                     ra1E,
    output logic [VecPkg::regAddrWidth-1:0]                     ra2E,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] srcAE,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] srcBE,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] immE,
    output logic                                                regWriteE,
    output logic                                                memWriteE,
    output logic                                                memToRegE
);

    VecPkg::VecInstr                                     instr;
    logic [3:0]                                          opcode;
    logic [1:0]                                          instrClass;
    logic                                                regWriteD;
    logic                                                memWriteD;
    logic                                                memToRegD;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] immD;

    assign instr      = instrD;
    assign opcode     = instr.regForm.opcode;
    assign instrClass = instr.regForm.instrClass;
    assign ra1        = instr.regForm.rn;

    always_comb begin
        case (instrClass)
            VecPkg::classReg:   ra2 = instr.regForm.rm;
            VecPkg::classStore: ra2 = instr.regForm.rd; // Store data register
            default:            ra2 = instr.regForm.rn; // No second source, avoids false hazards
        endcase
    end

    assign memWriteD = (instrClass == VecPkg::classStore);
    assign memToRegD = (instrClass == VecPkg::classLoad);
    assign regWriteD = memToRegD || (!memWriteD && opcode != VecPkg::opNop);

    // imm8 zero-extended and copied into every lane
    assign immD = {VecPkg::laneCount{VecPkg::laneWidth'(instr.immForm.imm8)}};

    always_ff @(posedge CLK) begin
        if (!rstN || bubble) begin
            aluOpE    <= VecPkg::opNop;
            classE    <= VecPkg::classReg;
            wa3E      <= '0;
            ra1E      <= '0;
            ra2E      <= '0;
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
        end else begin
            aluOpE    <= opcode;
            classE    <= instrClass;
            wa3E      <= instr.regForm.rd;
            ra1E      <= ra1;
            ra2E      <= ra2;
            regWriteE <= regWriteD;
            memWriteE <= memWriteD;
            memToRegE <= memToRegD;
        end
    end

    always_ff @(posedge CLK) begin
        srcAE <= rd1;
        srcBE <= rd2;
        immE  <= immD;
    end

endmodule

// File: logic/ExecuteStage.sv
module ExecuteStage (
    input  logic                                                CLK,
    input  logic                                                rstN,
    input  logic [3:0]                                          aluOpE,
    input  logic [1:0]                                          classE,
    input  logic [VecPkg::regAddrWidth-1:0]                     wa3E,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] srcAE,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] srcBE,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] immE,
    input  logic                                                regWriteE,
    input  logic                                                memWriteE,
    input  logic                                                memToRegE,
    input  logic [1:0]                                          forwardA,
    input  logic [1:0]                                          forwardB,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] resultW,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] aluResultM,
    output logic [VecPkg::memAddrWidth-1:0]                     memAddr0,
    output logic [VecPkg::memAddrWidth-1:0]                     memAddr1,
    output logic [VecPkg::memAddrWidth-1:0]                     memAddr2,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] writeData,
    output logic                                                memWrite,
    output logic                                                memToRegM,
    output logic                                                regWriteM,
    output logic [VecPkg::regAddrWidth-1:0]                     wa3M
);

    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] opA;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] opB;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] storeData;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] aluResult;
    logic [VecPkg::memAddrWidth-1:0]                     base;

    function automatic logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] forwardMux(
        input logic [1:0]                                          sel,
        input logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] regVal,
        input logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] wbVal,
        input logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] memVal
    );
        case (sel)
            2'd1:    return wbVal;
            2'd2:    return memVal;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        opA       = forwardMux(forwardA, srcAE, resultW, aluResultM);
        storeData = forwardMux(forwardB, srcBE, resultW, aluResultM);
        opB       = (classE == VecPkg::classReg) ? storeData : immE;
        for (int lane = 0; lane < VecPkg::laneCount; lane++) begin
            case (aluOpE)
                VecPkg::opAdd: aluResult[lane] = opA[lane] + opB[lane];
                VecPkg::opSub: aluResult[lane] = opA[lane] - opB[lane];
                VecPkg::opAnd: aluResult[lane] = opA[lane] & opB[lane];
                VecPkg::opOr:  aluResult[lane] = opA[lane] | opB[lane];
                VecPkg::opXor: aluResult[lane] = opA[lane] ^ opB[lane];
                VecPkg::opMov: aluResult[lane] = opB[lane];
                default:       aluResult[lane] = '0;
            endcase
        end
    end

    // Lane 0 of A plus the immediate, wrapping at 1024
    assign base = opA[0][VecPkg::memAddrWidth-1:0] + immE[0][VecPkg::memAddrWidth-1:0];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            memWrite  <= 1'b0;
            memToRegM <= 1'b0;
            regWriteM <= 1'b0;
            wa3M      <= '0;
        end else begin
            memWrite  <= memWriteE;
            memToRegM <= memToRegE;
            regWriteM <= regWriteE;
            wa3M      <= wa3E;
        end
    end

    always_ff @(posedge CLK) begin
        aluResultM <= aluResult;
        writeData  <= storeData;
        memAddr0   <= base;
        memAddr1   <= base + 1'b1;
        memAddr2   <= base - 1'b1;
    end

endmodule

// File: logic/FetchUnit.sv
module FetchUnit (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [VecPkg::instrWidth-1:0] instr,
    output logic [VecPkg::pcWidth-1:0]    pc,
    output logic [VecPkg::instrWidth-1:0] instrD
);

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc     <= '0;
            instrD <= VecPkg::nopInstr;
        end else begin
            if (!stall) begin
                pc <= pc + 1'b1; // Wraps at 256
            end
            if (flush) begin
                instrD <= VecPkg::nopInstr;
            end else if (!stall) begin
                instrD <= instr;
            end
        end
    end

endmodule

// File: logic/HazardUnit.sv
module HazardUnit (
    input  logic [VecPkg::regAddrWidth-1:0] ra1,
    input  logic [VecPkg::regAddrWidth-1:0] ra2,
    input  logic [VecPkg::regAddrWidth-1:0] ra1E,
    input  logic [VecPkg::regAddrWidth-1:0] ra2E,
    input  logic [VecPkg::regAddrWidth-1:0] wa3E,
    input  logic                            memToRegE,
    input  logic [VecPkg::regAddrWidth-1:0] wa3M,
    input  logic                            regWriteM,
    input  logic [VecPkg::regAddrWidth-1:0] wbReg,
    input  logic                            wbEn,
    output logic [1:0]                      forwardA,
    output logic [1:0]                      forwardB,
    output logic                            stall,
    output logic                            flush,
    output logic                            bubble
);

    logic loadUse;

    // Memory stage is younger than writeback, so it wins
    function automatic logic [1:0] pickSource(input logic [VecPkg::regAddrWidth-1:0] ra);
        if (regWriteM && wa3M == ra) begin
            return 2'd2;
        end else if (wbEn && wbReg == ra) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

    always_comb begin
        forwardA = pickSource(ra1E);
        forwardB = pickSource(ra2E);
    end

    assign loadUse = memToRegE && (wa3E == ra1 || wa3E == ra2);
    assign flush   = 1'b0; // No redirects exist, fetch is only cleared by reset
    assign stall   = loadUse;
    assign bubble  = loadUse || flush;

endmodule

// File: logic/VecCore.sv
module VecCore (
    input  logic                                                CLK,
    input  logic                                                rstN,
    input  logic [VecPkg::instrWidth-1:0]                       instr,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] readData,
    output logic [VecPkg::pcWidth-1:0]                          pc,
    output logic [VecPkg::memAddrWidth-1:0]                     memAddr0,
    output logic [VecPkg::memAddrWidth-1:0]                     memAddr1,
    output logic [VecPkg::memAddrWidth-1:0]                     memAddr2,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] writeData,
    output logic                                                memWrite
);

    logic [VecPkg::instrWidth-1:0]                       instrD;
    logic                                                stall;
    logic                                                flush;
    logic                                                bubble;
    logic [VecPkg::regAddrWidth-1:0]                     ra1;
    logic [VecPkg::regAddrWidth-1:0]                     ra2;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] rd1;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] rd2;
    logic [3:0]                                          aluOpE;
    logic [1:0]                                          classE;
    logic [VecPkg::regAddrWidth-1:0]                     wa3E;
    logic [VecPkg::regAddrWidth-1:0]                     ra1E;
    logic [VecPkg::regAddrWidth-1:0]                     ra2E;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] srcAE;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] srcBE;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] immE;
    logic                                                regWriteE;
    logic                                                memWriteE;
    logic                                                memToRegE;
    logic [1:0]                                          forwardA;
    logic [1:0]                                          forwardB;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] aluResultM;
    logic                                                memToRegM;
    logic                                                regWriteM;
    logic [VecPkg::regAddrWidth-1:0]                     wa3M;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] resultW;
    logic                                                wbEn;
    logic [VecPkg::regAddrWidth-1:0]                     wbReg;

    // *************************************************************************
    // Fetch and decode
    // *************************************************************************
    FetchUnit FetchUnit_inst (.CLK, .rstN, .stall, .flush, .instr, .pc, .instrD);

    VecRegFile VecRegFile_inst (
        .CLK, .rstN, .ra1, .ra2, .wa(wbReg), .we(wbEn), .wd(resultW), .rd1, .rd2
    );

    DecodeStage DecodeStage_inst (
        .CLK, .rstN, .bubble, .instrD, .rd1, .rd2, .ra1, .ra2, .aluOpE, .classE,
        .wa3E, .ra1E, .ra2E, .srcAE, .srcBE, .immE, .regWriteE, .memWriteE, .memToRegE
    );

    HazardUnit HazardUnit_inst (
        .ra1, .ra2, .ra1E, .ra2E, .wa3E, .memToRegE, .wa3M, .regWriteM, .wbReg, .wbEn,
        .forwardA, .forwardB, .stall, .flush, .bubble
    );

    // *************************************************************************
    // Execute, memory and writeback
    // *************************************************************************
    ExecuteStage ExecuteStage_inst (
        .CLK, .rstN, .aluOpE, .classE, .wa3E, .srcAE, .srcBE, .immE, .regWriteE,
        .memWriteE, .memToRegE, .forwardA, .forwardB, .resultW, .aluResultM,
        .memAddr0, .memAddr1, .memAddr2, .writeData, .memWrite, .memToRegM,
        .regWriteM, .wa3M
    );

    WritebackStage WritebackStage_inst (
        .CLK, .rstN, .readData, .aluResultM, .memToRegM, .regWriteM, .wa3M,
        .resultW, .wbEn, .wbReg
    );

endmodule

// File: logic/VecPkg.sv
package VecPkg;

    // *************************************************************************
    // Widths
    // *************************************************************************
    localparam int laneWidth    = 18;
    localparam int laneCount    = 3;
    localparam int regAddrWidth = 4;
    localparam int memAddrWidth = 10;
    localparam int pcWidth      = 8;
    localparam int instrWidth   = 28;

    // *************************************************************************
    // Opcodes and instruction classes
    // *************************************************************************
    localparam logic [3:0] opAdd = 4'h0;
    localparam logic [3:0] opSub = 4'h1;
    localparam logic [3:0] opAnd = 4'h2;
    localparam logic [3:0] opOr  = 4'h3;
    localparam logic [3:0] opXor = 4'h4;
    localparam logic [3:0] opMov = 4'h5; // Passes operand B
    localparam logic [3:0] opNop = 4'hF;

    localparam logic [1:0] classReg   = 2'd0;
    localparam logic [1:0] classImm   = 2'd1;
    localparam logic [1:0] classLoad  = 2'd2;
    localparam logic [1:0] classStore = 2'd3;

    localparam logic [instrWidth-1:0] nopInstr = {opNop, classReg, 22'd0};

    // Register form carries three indexes, immediate form swaps rm and pad for imm8
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [1:0] instrClass;
            logic [5:0] reserved;
            logic [3:0] rd;
            logic [3:0] rn;
            logic [3:0] rm;
            logic [3:0] pad;
        } regForm;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] instrClass;
            logic [5:0] reserved;
            logic [3:0] rd;
            logic [3:0] rn;
            logic [7:0] imm8;
        } immForm;
    } VecInstr;

endpackage

// File: logic/VecRegFile.sv
module VecRegFile (
    input  logic                                                   CLK,
    input  logic                                                   rstN,
    input  logic [VecPkg::regAddrWidth-1:0]                        ra1,
    input  logic [VecPkg::regAddrWidth-1:0]                        ra2,
    input  logic [VecPkg::regAddrWidth-1:0]                        wa,
    input  logic                                                   we,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0]    wd,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0]    rd1,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0]    rd2
);

    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] regs [2**VecPkg::regAddrWidth];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < 2**VecPkg::regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // Write-first, so decode sees the value retiring in writeback
    assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: logic/WritebackStage.sv
module WritebackStage (
    input  logic                                                CLK,
    input  logic                                                rstN,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] readData,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] aluResultM,
    input  logic                                                memToRegM,
    input  logic                                                regWriteM,
    input  logic [VecPkg::regAddrWidth-1:0]                     wa3M,
    output logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] resultW,
    output logic                                                wbEn,
    output logic [VecPkg::regAddrWidth-1:0]                     wbReg
);

    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] readDataW;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] aluResultW;
    logic                                                memToRegW;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            memToRegW <= 1'b0;
            wbEn      <= 1'b0;
            wbReg     <= '0;
        end else begin
            memToRegW <= memToRegM;
            wbEn      <= regWriteM;
            wbReg     <= wa3M;
        end
    end

    always_ff @(posedge CLK) begin
        readDataW  <= readData;
        aluResultW <= aluResultM;
    end

    assign resultW = memToRegW ? readDataW : aluResultW; // Loads return memory lanes

endmodule

// File: test/VecCoreChecker.sv
module VecCoreChecker (
    input  logic                                                CLK,
    input  logic                                                rstN,
    input  logic                                                memWrite,
    input  logic [VecPkg::memAddrWidth-1:0]                     memAddr0,
    input  logic [VecPkg::memAddrWidth-1:0]                     memAddr1,
    input  logic [VecPkg::memAddrWidth-1:0]                     memAddr2,
    input  logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] writeData,
    input  logic [VecPkg::pcWidth-1:0]                          pc,
    output logic                                                allStoresSeen
);

    logic [VecPkg::memAddrWidth-1:0]                     expAddr [$];
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] expData [$];
    int expPc    [$];
    int expCycle [$];
    int errorCount    = 0;
    int storeCount    = 0;
    int expectedTotal = 0;
    int activeCycles  = 0;

    assign allStoresSeen = (expectedTotal > 0) && (storeCount >= expectedTotal);

    task automatic expectStore(
        input logic [VecPkg::memAddrWidth-1:0]                     addr,
        input logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] data
    );
        expAddr.push_back(addr);
        expData.push_back(data);
        expectedTotal++;
    endtask

    task automatic expectStoreTiming(input int storePc, input int storeCycle);
        expPc.push_back(storePc);
        expCycle.push_back(storeCycle);
    endtask

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED store %0d %s expected %h actual %h", storeCount, name, expected,
                     actual);
            errorCount++;
        end
    endtask

    task automatic checkStore();
        logic [VecPkg::memAddrWidth-1:0]                     a0;
        logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] d;
        int                                                  wantPc;
        int                                                  wantCycle;
        storeCount++;
        if (expAddr.size() == 0) begin
            $display("Store %0d to address %h came after the expected list was used up",
                     storeCount, memAddr0);
            errorCount++;
        end else begin
            a0 = expAddr.pop_front();
            d  = expData.pop_front();
            compareField("memAddr0", a0, memAddr0);
            compareField("memAddr1", (int'(a0) + 1) % (2**VecPkg::memAddrWidth), memAddr1);
            compareField("memAddr2", (int'(a0) + 2**VecPkg::memAddrWidth - 1)
                         % (2**VecPkg::memAddrWidth), memAddr2);
            for (int lane = 0; lane < VecPkg::laneCount; lane++) begin
                compareField($sformatf("writeData[%0d]", lane), d[lane], writeData[lane]);
            end
            if (expPc.size() == 0) begin
                $display("Store %0d has no store instruction in the program behind it",
                         storeCount);
                errorCount++;
            end else begin
                wantPc    = expPc.pop_front();
                wantCycle = expCycle.pop_front();
                compareField("pc", wantPc % (2**VecPkg::pcWidth), pc);
                if (activeCycles != wantCycle) begin
                    $display("Store %0d came %0d cycles after reset instead of %0d",
                             storeCount, activeCycles, wantCycle);
                    errorCount++;
                end
            end
        end
    endtask

    task automatic reportMissing();
        if (expAddr.size() != 0) begin
            $display("%0d expected stores never appeared on the store port", expAddr.size());
            errorCount += expAddr.size();
        end
    endtask

    // Counts the cycles since reset was released
    always @(negedge CLK) begin
        if (rstN) begin
            activeCycles <= activeCycles + 1;
        end
    end

    // Outputs are registered in the DUT, so the falling edge sees settled values
    always @(negedge CLK) begin
        if (!rstN) begin
            if (memWrite !== 1'b0) begin
                $display("memWrite was not low while reset was asserted");
                errorCount++;
            end
        end else if (memWrite === 1'b1) begin
            checkStore();
        end else if (memWrite !== 1'b0) begin
            $display("memWrite is unknown after reset");
            errorCount++;
        end
    end

endmodule

// File: test/VecCoreTb.sv
module VecCoreTb;

    logic                                                CLK = 1'b0;
    logic                                                rstN;
    logic [VecPkg::instrWidth-1:0]                       instr;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] readData;
    logic [VecPkg::pcWidth-1:0]                          pc;
    logic [VecPkg::memAddrWidth-1:0]                     memAddr0;
    logic [VecPkg::memAddrWidth-1:0]                     memAddr1;
    logic [VecPkg::memAddrWidth-1:0]                     memAddr2;
    logic [VecPkg::laneCount-1:0][VecPkg::laneWidth-1:0] writeData;
    logic                                                memWrite;
    logic                                                allStoresSeen;

    logic [VecPkg::instrWidth-1:0] imem [2**VecPkg::pcWidth];
    logic [VecPkg::laneWidth-1:0]  dmem [2**VecPkg::memAddrWidth];
    int programWords = 0;
    int tbErrors     = 0;
    int cycleCount   = 0;
    int cycleLimit   = 0;

    VecCore VecCore_inst (
        .CLK, .rstN, .instr, .readData, .pc, .memAddr0, .memAddr1, .memAddr2,
        .writeData, .memWrite
    );

    VecCoreChecker storeCheck (
        .CLK, .rstN, .memWrite, .memAddr0, .memAddr1, .memAddr2, .writeData, .pc,
        .allStoresSeen
    );

    // *************************************************************************
    // Memory models
    // *************************************************************************
    assign instr = (^pc === 1'bx) ? VecPkg::nopInstr : imem[pc]; // NOP fill past the program
    assign readData = (^{memAddr2, memAddr1, memAddr0} === 1'bx) ? '0
                    : {dmem[memAddr2], dmem[memAddr1], dmem[memAddr0]};

    always @(posedge CLK) begin
        if (memWrite === 1'b1) begin
            dmem[memAddr0] <= writeData[0];
            dmem[memAddr1] <= writeData[1];
            dmem[memAddr2] <= writeData[2];
        end
    end

    initial begin
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
    end

    // Source registers as the instruction encoding defines them
    function automatic logic readsRegister(input VecPkg::VecInstr w,
                                           input logic [VecPkg::regAddrWidth-1:0] r);
        if (w.regForm.rn == r) begin
            return 1'b1;
        end
        if (w.regForm.instrClass == VecPkg::classReg) begin
            return w.regForm.rm == r;
        end
        return w.regForm.instrClass == VecPkg::classStore && w.regForm.rd == r;
    endfunction

    task automatic loadVectors();
        int               fd;
        int               got;
        int               need;
        int               stalls;
        logic [7:0]       kind;
        logic [31:0]      f0;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [8*128-1:0] rest;
        VecPkg::VecInstr  word;
        VecPkg::VecInstr  prev;
        stalls = 0;
        prev   = VecPkg::nopInstr;
        for (int a = 0; a < 2**VecPkg::pcWidth; a++) begin
            imem[a] = VecPkg::nopInstr;
        end
        for (int a = 0; a < 2**VecPkg::memAddrWidth; a++) begin
            dmem[a] = {8'h2A, 10'(a)}; // Every word carries its own address
        end
        fd = $fopen("test/vecCoreVectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/vecCoreVectors.txt");
            tbErrors++;
            return;
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "I": begin
                    need = 1;
                    got  = $fscanf(fd, "%h", f0);
                    word = f0[VecPkg::instrWidth-1:0];
                    imem[programWords] = word;
                    if (prev.regForm.instrClass == VecPkg::classLoad
                            && readsRegister(word, prev.regForm.rd)) begin
                        stalls++; // Load-use pair costs one cycle
                    end
                    if (word.regForm.instrClass == VecPkg::classStore) begin
                        // A store reaches M three cycles after its fetch plus every stall
                        storeCheck.expectStoreTiming(programWords + 3,
                                                     programWords + 3 + stalls);
                    end
                    prev = word;
                    programWords++;
                end
                "M": begin
                    need = 2;
                    got  = $fscanf(fd, "%h %h", f0, f1);
                    dmem[f0[VecPkg::memAddrWidth-1:0]] = f1[VecPkg::laneWidth-1:0];
                end
                "S": begin
                    need = 4;
                    got  = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                    storeCheck.expectStore(f0[VecPkg::memAddrWidth-1:0],
                        {f3[VecPkg::laneWidth-1:0], f2[VecPkg::laneWidth-1:0],
                         f1[VecPkg::laneWidth-1:0]});
                end
                default: begin
                    got  = $fgets(rest, fd); // Comment line
                    need = got;
                end
            endcase
            if (got != need) begin
                $display("Malformed %s line in the vector file", kind);
                tbErrors++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rstN = 1'b0;
        loadVectors();
        cycleLimit = 16 + programWords + 40;
        repeat (16) @(posedge CLK);
        rstN <= 1'b1;
        while (!allStoresSeen && cycleCount < cycleLimit) begin
            @(posedge CLK);
        end
        if (allStoresSeen) begin
            repeat (8) @(posedge CLK); // Let the pipeline drain so a stray store shows up
        end else begin
            $display("Run stopped at the cycle limit of %0d with stores still missing",
                     cycleLimit);
            tbErrors++;
        end
        storeCheck.reportMissing();
        $display("Errors: %0d  stores seen: %0d of %0d", tbErrors + storeCheck.errorCount,
                 storeCheck.storeCount, storeCheck.expectedTotal);
        if (tbErrors + storeCheck.errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: test/vecCoreVectors.txt
# I instr | M addr word | S addr0 lane0 lane1 lane2
# All values are hex and S lines follow program order
M 010 00300
M 011 3FF00
M 00F 12345
M 000 0F0F0
M 001 2AAAA
M 3FF 1FFFF
I 0801010
I 0002110
I 5403025
I 1004230
I 0C04020
I 0805000
I 2006450
I 3007610
I 4008720
I 0C06030
I 0C07040
I 0C08050
I 04091FF
I 500A090
I 100B310
I 0C0A1FF
I 0C0B000
S 020 005DB 3FDDB 24665
S 030 000D0 2A88A 04665
S 040 003D0 3FF8A 16765
S 050 005D0 0018A 321EF
S 3FF 003FF 3FFFF 12444
S 000 3FD25 00125 2DCE0
